//--- hdl/blackjack_pkg.sv
package blackjack_pkg;

    // ------------------------------------------------------------
    // widths and card / score types
    // ------------------------------------------------------------
    typedef logic [3:0] card_t;     // 1 = ace, 10 = ten or face
    typedef logic [5:0] score_t;    // raw sum or best score of a hand
    typedef logic [3:0] bet_t;      // 1..15 coins

    // scoring rules
    localparam int BUST_LIMIT   = 21;   // above this a hand is bust
    localparam int DEALER_STAND = 17;   // dealer stops drawing here
    localparam int ACE_BONUS    = 10;   // one ace counted as 11

    // ------------------------------------------------------------
    // game phases
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        BETTING,
        DEAL,
        PLAYER_TURN,
        DEALER_TURN,
        DEALER_SETTLE,
        RESULT
    } game_state_t;

    // round outcome, also selects the payout
    typedef enum logic [2:0] {
        NONE,
        LOSE,
        DRAW,
        WIN,
        NATURAL_WIN
    } outcome_t;

endpackage

//--- hdl/card_shuffler.sv
module card_shuffler import blackjack_pkg::*; #(
    parameter logic [15:0] SHUFFLE_SEED = 16'hACE1
) (
    input  logic  clk,
    input  logic  reset,
    output card_t card
);

    localparam logic [15:0] FEEDBACK_MASK = 16'hB400;

    logic [15:0] lfsr;
    logic [3:0]  rank;     // 0..12 after the modulo

    // galois lfsr, advances every cycle whether or not a card is drawn
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= SHUFFLE_SEED;
        end else if (lfsr[0]) begin
            lfsr <= (lfsr >> 1) ^ FEEDBACK_MASK;
        end else begin
            lfsr <= lfsr >> 1;
        end
    end

    // low nibble modulo 13, one subtract is enough for 0..15
    always_comb begin
        if (lfsr[3:0] >= 4'd13) begin
            rank = lfsr[3:0] - 4'd13;
        end else begin
            rank = lfsr[3:0];
        end
    end

    // jack, queen and king all count as ten
    always_comb begin
        if (rank >= 4'd9) begin
            card = card_t'(10);
        end else begin
            card = card_t'(rank + 4'd1);
        end
    end

endmodule

//--- hdl/hand_scorer.sv
module hand_scorer import blackjack_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   clear,
    input  logic   add,
    input  card_t  card,
    output score_t score,
    output logic   natural
);

    score_t     raw_sum;        // every ace counted as 1
    logic       ace_seen;
    logic [1:0] card_count;     // saturates at 3

    score_t     sum_next;
    logic       ace_next;
    logic [1:0] count_next;
    score_t     best_next;

    // ------------------------------------------------------------
    // next hand values with the incoming card folded in
    // ------------------------------------------------------------
    always_comb begin
        sum_next   = raw_sum + score_t'(card);
        ace_next   = ace_seen | (card == card_t'(1));
        count_next = (card_count == 2'd3) ? card_count : card_count + 2'd1;

        // at most one ace can ever count as 11
        if (ace_next && (sum_next + score_t'(ACE_BONUS) <= score_t'(BUST_LIMIT))) begin
            best_next = sum_next + score_t'(ACE_BONUS);
        end else begin
            best_next = sum_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raw_sum    <= '0;
            ace_seen   <= 1'b0;
            card_count <= '0;
            score      <= '0;
        end else if (clear) begin
            raw_sum    <= '0;
            ace_seen   <= 1'b0;
            card_count <= '0;
            score      <= '0;
        end else if (add) begin
            raw_sum    <= sum_next;
            ace_seen   <= ace_next;
            card_count <= count_next;
            score      <= best_next;   // visible the cycle after add
        end
    end

    // two-card 21
    assign natural = (score == score_t'(BUST_LIMIT)) && (card_count == 2'd2);

endmodule

//--- hdl/game_fsm.sv
module game_fsm import blackjack_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     hit,
    input  logic     stand,
    input  logic     next,
    input  logic     bet_taken,
    input  card_t    card,
    input  score_t   player_score,
    input  score_t   dealer_score,
    input  logic     player_natural,
    output logic     bet_window,
    output logic     hand_clear,
    output logic     player_add,
    output logic     dealer_add,
    output logic     settle,
    output logic     player_card_valid,
    output logic     dealer_card_valid,
    output logic     win,
    output logic     lose,
    output logic     draw,
    output card_t    player_card,
    output card_t    dealer_card,
    output outcome_t outcome
);

    game_state_t state;
    logic [1:0]  deal_idx;      // P, D, P, D
    logic        turn_wait;     // lets the player score settle
    logic        done;          // flags already raised this round
    outcome_t    outcome_next;

    assign done = win | lose | draw;

    // ------------------------------------------------------------
    // strobes decoded from the phase
    // ------------------------------------------------------------
    assign bet_window = (state == BETTING);
    assign hand_clear = (state == BETTING) && bet_taken;   // clears on entry to DEAL

    assign player_add = ((state == DEAL) && !deal_idx[0]) ||
                        ((state == PLAYER_TURN) && !turn_wait && hit && !stand &&
                         (player_score < score_t'(BUST_LIMIT)));
    assign dealer_add = ((state == DEAL) && deal_idx[0]) ||
                        ((state == DEALER_TURN) && (dealer_score < score_t'(DEALER_STAND)));

    // outcome rule, bust player loses even if dealer also busts
    always_comb begin
        if (player_score > score_t'(BUST_LIMIT)) begin
            outcome_next = LOSE;
        end else if ((dealer_score > score_t'(BUST_LIMIT)) || (player_score > dealer_score)) begin
            outcome_next = player_natural ? NATURAL_WIN : WIN;
        end else if (player_score == dealer_score) begin
            outcome_next = DRAW;
        end else begin
            outcome_next = LOSE;
        end
    end

    // ------------------------------------------------------------
    // phase register
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= BETTING;
            deal_idx  <= '0;
            turn_wait <= 1'b0;
            settle    <= 1'b0;
            win       <= 1'b0;
            lose      <= 1'b0;
            draw      <= 1'b0;
            outcome   <= NONE;
        end else begin
            settle <= 1'b0;
            case (state)
                BETTING: begin
                    if (bet_taken) begin
                        state    <= DEAL;
                        deal_idx <= '0;
                    end
                end
                DEAL: begin
                    deal_idx <= deal_idx + 2'd1;
                    if (deal_idx == 2'd3) begin
                        state     <= PLAYER_TURN;
                        turn_wait <= 1'b1;
                    end
                end
                PLAYER_TURN: begin
                    if (turn_wait) begin
                        turn_wait <= 1'b0;           // hits dropped here
                    end else if (player_score > score_t'(BUST_LIMIT)) begin
                        state <= RESULT;
                    end else if (stand || (player_score == score_t'(BUST_LIMIT))) begin
                        state <= DEALER_TURN;
                    end else if (hit) begin
                        turn_wait <= 1'b1;
                    end
                end
                DEALER_TURN: begin
                    if (dealer_score < score_t'(DEALER_STAND)) begin
                        state <= DEALER_SETTLE;      // card taken this cycle
                    end else begin
                        state <= RESULT;
                    end
                end
                DEALER_SETTLE: state <= DEALER_TURN;
                RESULT: begin
                    if (!done) begin
                        outcome <= outcome_next;
                        settle  <= 1'b1;
                        win     <= (outcome_next == WIN) || (outcome_next == NATURAL_WIN);
                        lose    <= (outcome_next == LOSE);
                        draw    <= (outcome_next == DRAW);
                    end else if (next) begin
                        state   <= BETTING;
                        outcome <= NONE;
                        win     <= 1'b0;
                        lose    <= 1'b0;
                        draw    <= 1'b0;
                    end
                end
                default: state <= BETTING;
            endcase
        end
    end

    // registered copies of each dealt card
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player_card_valid <= 1'b0;
            dealer_card_valid <= 1'b0;
        end else begin
            player_card_valid <= player_add;
            dealer_card_valid <= dealer_add;
        end
    end

    always_ff @(posedge clk) begin
        if (player_add) begin
            player_card <= card;
        end
        if (dealer_add) begin
            dealer_card <= card;
        end
    end

endmodule

//--- hdl/coin_bank.sv
module coin_bank import blackjack_pkg::*; #(
    parameter int COIN_WIDTH  = 8,
    parameter int START_COINS = 30
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bet_window,
    input  logic                  settle,
    input  bet_t                  bet,
    input  outcome_t              outcome,
    output logic                  bet_taken,
    output logic [COIN_WIDTH-1:0] coins
);

    bet_t                stake;        // held until settle
    logic [COIN_WIDTH:0] payout;
    logic [COIN_WIDTH:0] purse_sum;    // one spare bit to catch overflow

    // a bet must be nonzero and covered by the purse
    assign bet_taken = bet_window && (bet != '0) && (COIN_WIDTH'(bet) <= coins);

    // ------------------------------------------------------------
    // payout table
    // ------------------------------------------------------------
    always_comb begin
        case (outcome)
            NATURAL_WIN: payout = (COIN_WIDTH + 1)'(stake) << 2;
            WIN:         payout = (COIN_WIDTH + 1)'(stake) << 1;
            DRAW:        payout = (COIN_WIDTH + 1)'(stake);
            default:     payout = '0;     // lose keeps nothing
        endcase
        purse_sum = {1'b0, coins} + payout;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins <= COIN_WIDTH'(START_COINS);
        end else if (bet_taken) begin
            coins <= coins - COIN_WIDTH'(bet);
        end else if (settle) begin
            if (purse_sum[COIN_WIDTH]) begin
                coins <= '1;                 // saturate at full purse
            end else begin
                coins <= purse_sum[COIN_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bet_taken) begin
            stake <= bet;
        end
    end

endmodule

//--- hdl/blackjack_top.sv
module blackjack_top import blackjack_pkg::*; #(
    parameter int          COIN_WIDTH   = 8,
    parameter int          START_COINS  = 30,
    parameter logic [15:0] SHUFFLE_SEED = 16'hACE1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hit,
    input  logic                  stand,
    input  logic                  next,
    input  bet_t                  bet,
    output card_t                 player_card,
    output card_t                 dealer_card,
    output logic                  player_card_valid,
    output logic                  dealer_card_valid,
    output score_t                player_score,
    output score_t                dealer_score,
    output logic [COIN_WIDTH-1:0] coins,
    output logic                  win,
    output logic                  lose,
    output logic                  draw
);

    card_t    card;
    logic     bet_window;
    logic     bet_taken;
    logic     hand_clear;
    logic     player_add;
    logic     dealer_add;
    logic     player_natural;
    logic     settle;
    outcome_t outcome;

    card_shuffler #(
        .SHUFFLE_SEED (SHUFFLE_SEED)
    ) u_shuffler (
        .clk   (clk),
        .reset (reset),
        .card  (card)
    );

    // ------------------------------------------------------------
    // one scorer per hand, both fed from the shared card
    // ------------------------------------------------------------
    hand_scorer u_player_hand (
        .clk     (clk),
        .reset   (reset),
        .clear   (hand_clear),
        .add     (player_add),
        .card    (card),
        .score   (player_score),
        .natural (player_natural)
    );

    hand_scorer u_dealer_hand (
        .clk     (clk),
        .reset   (reset),
        .clear   (hand_clear),
        .add     (dealer_add),
        .card    (card),
        .score   (dealer_score),
        .natural ()
    );

    game_fsm u_fsm (
        .clk               (clk),
        .reset             (reset),
        .hit               (hit),
        .stand             (stand),
        .next              (next),
        .bet_taken         (bet_taken),
        .card              (card),
        .player_score      (player_score),
        .dealer_score      (dealer_score),
        .player_natural    (player_natural),
        .bet_window        (bet_window),
        .hand_clear        (hand_clear),
        .player_add        (player_add),
        .dealer_add        (dealer_add),
        .settle            (settle),
        .player_card_valid (player_card_valid),
        .dealer_card_valid (dealer_card_valid),
        .win               (win),
        .lose              (lose),
        .draw              (draw),
        .player_card       (player_card),
        .dealer_card       (dealer_card),
        .outcome           (outcome)
    );

    coin_bank #(
        .COIN_WIDTH  (COIN_WIDTH),
        .START_COINS (START_COINS)
    ) u_bank (
        .clk        (clk),
        .reset      (reset),
        .bet_window (bet_window),
        .settle     (settle),
        .bet        (bet),
        .outcome    (outcome),
        .bet_taken  (bet_taken),
        .coins      (coins)
    );

endmodule

//--- testbench/tb_blackjack.sv
module tb_blackjack import blackjack_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int COIN_WIDTH       = 6;     // small purse so saturation is reached
    localparam int START_COINS      = 30;
    localparam int COIN_MAX         = (1 << COIN_WIDTH) - 1;
    localparam int CLK_PERIOD       = 20;
    localparam int ROUNDS           = 200;
    localparam int CYCLES_PER_ROUND = 100;

    logic                  clk;
    logic                  reset;
    logic                  hit;
    logic                  stand;
    logic                  next;
    bet_t                  bet;
    card_t                 player_card;
    card_t                 dealer_card;
    logic                  player_card_valid;
    logic                  dealer_card_valid;
    score_t                player_score;
    score_t                dealer_score;
    logic [COIN_WIDTH-1:0] coins;
    logic                  win;
    logic                  lose;
    logic                  draw;

    int          errors;
    int          rounds_played;
    int          invalid_bets;
    logic [31:0] rng;
    int          purse;          // model purse
    int          stake;
    int          p_raw;          // model hands, aces as 1
    int          d_raw;
    int          p_cnt;
    int          d_cnt;
    bit          p_ace;
    bit          d_ace;

    blackjack_top #(
        .COIN_WIDTH  (COIN_WIDTH),
        .START_COINS (START_COINS)
    ) uut (
        .clk               (clk),
        .reset             (reset),
        .hit               (hit),
        .stand             (stand),
        .next              (next),
        .bet               (bet),
        .player_card       (player_card),
        .dealer_card       (dealer_card),
        .player_card_valid (player_card_valid),
        .dealer_card_valid (dealer_card_valid),
        .player_score      (player_score),
        .dealer_score      (dealer_score),
        .coins             (coins),
        .win               (win),
        .lose              (lose),
        .draw              (draw)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // model of the table rules
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one ace may count as 11 if the hand stays at 21 or under
    function automatic int best_score(input int raw, input bit ace);
        if (ace && (raw + 10 <= 21)) begin
            return raw + 10;
        end
        return raw;
    endfunction

    function automatic outcome_t expected_outcome(input int ps, input int ds, input int pcards);
        if (ps > 21) begin
            return LOSE;
        end else if ((ds > 21) || (ps > ds)) begin
            return ((ps == 21) && (pcards == 2)) ? NATURAL_WIN : WIN;
        end else if (ps == ds) begin
            return DRAW;
        end
        return LOSE;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_score(input string name, input score_t actual, input score_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_card(input string name, input card_t value);
        if ((value < card_t'(1)) || (value > card_t'(10))) begin
            $display("[FAIL] %s got 0x%h outside 0x1..0xa", name, value);
            errors++;
        end
    endtask

    task automatic check_coins(input logic [COIN_WIDTH-1:0] actual,
                               input logic [COIN_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] coins got 0x%h expected 0x%h", actual, expected);
            errors++;
        end
    endtask

    task automatic check_outcome(input outcome_t expected);
        logic [2:0] want;
        want[2] = (expected == WIN) || (expected == NATURAL_WIN);
        want[1] = (expected == LOSE);
        want[0] = (expected == DRAW);
        if ({win, lose, draw} !== want) begin
            $display("[FAIL] {win,lose,draw} got 0x%h expected 0x%h", {win, lose, draw}, want);
            errors++;
        end
    endtask

    // one clock, then sample registered outputs before driving
    task automatic step();
        @(posedge clk);
        #2;
        if (player_card_valid) begin
            check_card("player_card", player_card);
            p_raw = p_raw + int'(player_card);
            p_ace = p_ace | (player_card == card_t'(1));
            p_cnt++;
            check_score("player_score", player_score, score_t'(best_score(p_raw, p_ace)));
        end
        if (dealer_card_valid) begin
            check_card("dealer_card", dealer_card);
            d_raw = d_raw + int'(dealer_card);
            d_ace = d_ace | (dealer_card == card_t'(1));
            d_cnt++;
            check_score("dealer_score", dealer_score, score_t'(best_score(d_raw, d_ace)));
        end
    endtask

    // ------------------------------------------------------------
    // round phases
    // ------------------------------------------------------------
    task automatic place_bet();
        bit   accepted;
        bet_t bet_val;
        accepted = 1'b0;
        while (!accepted) begin
            p_raw = 0;
            d_raw = 0;
            p_cnt = 0;
            d_cnt = 0;
            p_ace = 1'b0;
            d_ace = 1'b0;
            rng = lcg_step(rng);
            bet_val = rng[19:16];    // 0 and over-purse bets included
            bet = bet_val;
            step();
            if ((bet_val != '0) && (int'(bet_val) <= purse)) begin
                accepted = 1'b1;
                purse = purse - int'(bet_val);
                stake = int'(bet_val);
                bet = '0;
                check_coins(coins, COIN_WIDTH'(purse));
                repeat (4) step();   // P, D, P, D
                if ((p_cnt != 2) || (d_cnt != 2)) begin
                    $display("deal gave %0d player and %0d dealer cards instead of 2 each",
                             p_cnt, d_cnt);
                    errors++;
                end
            end else begin
                repeat (2) step();
                bet = '0;
                invalid_bets++;
                check_coins(coins, COIN_WIDTH'(purse));
                if ((p_cnt != 0) || (d_cnt != 0)) begin
                    $display("cards were dealt after an invalid bet of %0d", bet_val);
                    errors++;
                end
            end
        end
    endtask

    task automatic player_turn();
        bit turn_over;
        bit do_hit;
        int ps;
        int cards_before;
        turn_over = 1'b0;
        while (!turn_over) begin
            ps = best_score(p_raw, p_ace);
            rng = lcg_step(rng);
            do_hit = (ps < 12) || ((ps < 17) && rng[27]) || ((ps < 20) && (rng[26:24] == 3'd0));
            if (ps >= 21) begin
                turn_over = 1'b1;            // fsm moves on by itself
            end else if (do_hit) begin
                hit = 1'b1;                  // held until the card shows up
                cards_before = p_cnt;
                while (p_cnt == cards_before) begin
                    step();
                end
                hit = 1'b0;
            end else begin
                stand = 1'b1;
                repeat (2) step();           // covers the settle cycle
                stand = 1'b0;
                turn_over = 1'b1;
            end
        end
    endtask

    task automatic finish_round();
        int       ps;
        int       ds;
        outcome_t exp_outcome;
        while (!(win || lose || draw)) begin
            step();
        end
        ps = best_score(p_raw, p_ace);
        ds = best_score(d_raw, d_ace);
        if ((ps <= 21) && (ds < 17)) begin
            $display("dealer stopped drawing at %0d, below 17", ds);
            errors++;
        end
        exp_outcome = expected_outcome(ps, ds, p_cnt);
        check_outcome(exp_outcome);
        case (exp_outcome)
            NATURAL_WIN: purse = purse + 4 * stake;
            WIN:         purse = purse + 2 * stake;
            DRAW:        purse = purse + stake;
            default:     purse = purse;
        endcase
        if (purse > COIN_MAX) begin
            purse = COIN_MAX;
        end
        step();                              // payout lands one cycle later
        check_coins(coins, COIN_WIDTH'(purse));
        next = 1'b1;
        step();
        next = 1'b0;
        check_outcome(NONE);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        errors = 0;
        rounds_played = 0;
        invalid_bets = 0;
        rng = 32'haad4eee4;
        purse = START_COINS;
        stake = 0;
        reset = 1'b1;
        hit = 1'b0;
        stand = 1'b0;
        next = 1'b0;
        bet = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        check_coins(coins, COIN_WIDTH'(START_COINS));
        check_score("player_score", player_score, '0);
        check_score("dealer_score", dealer_score, '0);
        check_outcome(NONE);

        while ((rounds_played < ROUNDS) && (purse > 0)) begin
            place_bet();
            player_turn();
            finish_round();
            rounds_played++;
        end

        $display("%0d rounds, %0d invalid bets, purse %0d, %0d errors",
                 rounds_played, invalid_bets, purse, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized for the longest expected run
    initial begin
        #(ROUNDS * CYCLES_PER_ROUND * CLK_PERIOD);
        $display("timeout after %0d rounds, the table stopped responding", rounds_played);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- all.f
hdl/blackjack_pkg.sv
hdl/card_shuffler.sv
hdl/hand_scorer.sv
hdl/game_fsm.sv
hdl/coin_bank.sv
hdl/blackjack_top.sv
testbench/tb_blackjack.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the blackjack testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_blackjack \
    --Mdir obj_dir \
    -o tb_blackjack \
    -f all.f

./obj_dir/tb_blackjack > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
